//--- flist.f
+incdir+src
src/vng_pkg.sv
src/vng_state_seq.sv
src/vng_tap_shiftreg.sv
src/vng_ctrl_rom.sv
src/vng_axes.sv
src/vng_diag.sv
src/vng_pipedelay.sv
src/vng_top.sv
sim/tb_vng_top.sv

//--- sim/tb_vng_top.sv
`include "vng_defs.svh"

module tb_vng_top;

    import vng_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int RUN_CYCLES   = 4 + 12 + 28 + 40 + 72 + 26;
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + RUN_CYCLES);

    logic   clk;
    logic   rst_n;
    logic   clk_en;
    logic   px_push;
    pixel_t px_in;
    pixel_t axes_hv;
    logic   axes_h_push;
    logic   axes_v_push;
    logic   axes_red_push;
    sum_t   axes_red;
    logic   axes_green_push;
    sum_t   axes_green;
    logic   axes_blue_push;
    sum_t   axes_blue;

    // reference state, updated on each enabled edge
    phase_t     m_st;
    pixel_t     m_hist [`VNG_TAPS];
    axes_ctrl_t m_ctrl;
    pixel_t     m_hv;
    sum_t       m_add;
    sum_t       m_add_prev;
    sum_t       m_dbl;
    sum_t       m_diag;
    sum_t       m_red [`VNG_RED_DELAY];

    integer seed = 97205;
    int     n_tests = 0;
    int     n_checks = 0;
    int     n_errors = 0;
    int     errs_at_start = 0;
    int     cycles = 0;

    vng_top i_vng_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .clk_en          (clk_en),
        .px_push         (px_push),
        .px_in           (px_in),
        .axes_hv         (axes_hv),
        .axes_h_push     (axes_h_push),
        .axes_v_push     (axes_v_push),
        .axes_red_push   (axes_red_push),
        .axes_red        (axes_red),
        .axes_green_push (axes_green_push),
        .axes_green      (axes_green),
        .axes_blue_push  (axes_blue_push),
        .axes_blue       (axes_blue)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped, no result after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            n_errors++;
        end
    endtask

    // drive one cycle, then step the reference as the edge does
    task automatic tick(input logic en, input logic push, input pixel_t px);
        pixel_t               a;
        pixel_t               b;
        sum_t                 pre;
        logic [`VNG_DATA+1:0] pair;
        clk_en  = en;
        px_push = push;
        px_in   = px;
        @(posedge clk);
        #10;
        if (en) begin
            case (m_ctrl.red_sel)
                red_add:  pre = m_add;
                red_diag: pre = m_diag;
                default:  pre = m_dbl;
            endcase
            if (m_ctrl.red_push) begin
                for (int i = `VNG_RED_DELAY - 1; i > 0; i--) m_red[i] = m_red[i-1];
                m_red[0] = pre;
            end
            pair       = {1'b0, m_add} + {1'b0, m_add_prev};
            m_diag     = pair[`VNG_DATA+1:1];
            m_add_prev = m_add;
            a          = m_hist[TAP_A_IDX[m_st]];
            b          = m_hist[TAP_B_IDX[m_st]];
            m_ctrl     = CTRL_TABLE[m_st];
            m_hv       = (a > b) ? a - b : b - a;
            m_add      = {1'b0, a} + {1'b0, b};
            m_dbl      = {a, 1'b0};
            if (push) begin
                for (int i = `VNG_TAPS - 1; i > 0; i--) m_hist[i] = m_hist[i-1];
                m_hist[0] = px;
                m_st = (m_st == `VNG_STATES - 1) ? '0 : m_st + 1'b1;
            end
        end
    endtask

    task automatic check_outputs();
        sum_t exp_green;
        sum_t exp_blue;
        exp_green = m_ctrl.green_sel ? m_add : m_dbl;
        exp_blue  = m_ctrl.blue_sel ? m_add : m_dbl;
        check_val("axes_h_push", axes_h_push, m_ctrl.h_push);
        check_val("axes_v_push", axes_v_push, !m_ctrl.h_push);
        check_val("axes_red_push", axes_red_push, m_ctrl.red_push);
        check_val("axes_green_push", axes_green_push, m_ctrl.green_push);
        check_val("axes_blue_push", axes_blue_push, m_ctrl.blue_push);
        // datapath has no reset, skip values still unknown in the reference
        if (!$isunknown(m_hv)) check_val("axes_hv", axes_hv, m_hv);
        if (!$isunknown(exp_green)) check_val("axes_green", axes_green, exp_green);
        if (!$isunknown(exp_blue)) check_val("axes_blue", axes_blue, exp_blue);
        if (!$isunknown(m_red[`VNG_RED_DELAY-1])) begin
            check_val("axes_red", axes_red, m_red[`VNG_RED_DELAY-1]);
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = n_errors - errs_at_start;
        n_tests++;
        if (errs == 0) $display("%-16s ok", name);
        else $display("%-16s %0d errors", name, errs);
        errs_at_start = n_errors;
    endtask

    task automatic idle_after_reset();
        for (int i = 0; i < 4; i++) begin
            tick(1'b0, 1'b1, pixel_t'($random(seed)));
            check_val("axes_h_push", axes_h_push, 1'b0);
            check_val("axes_v_push", axes_v_push, 1'b1);
            check_val("axes_red_push", axes_red_push, 1'b0);
            check_val("axes_green_push", axes_green_push, 1'b0);
            check_val("axes_blue_push", axes_blue_push, 1'b0);
        end
        finish_test("idle_after_reset");
    endtask

    task automatic strobe_sequence();
        phase_t s;
        for (int i = 0; i < 12; i++) begin
            s = m_st;
            tick(1'b1, 1'b1, pixel_t'($random(seed)));
            check_val("axes_h_push", axes_h_push, CTRL_TABLE[s].h_push);
            check_val("axes_v_push", axes_v_push, !CTRL_TABLE[s].h_push);
            check_val("axes_green_push", axes_green_push, CTRL_TABLE[s].green_push);
            check_val("axes_blue_push", axes_blue_push, CTRL_TABLE[s].blue_push);
            check_outputs();
        end
        finish_test("strobe_sequence");
    endtask

    task automatic constant_stream();
        pixel_t p;
        p = pixel_t'($random(seed));
        for (int i = 0; i < 28; i++) begin
            tick(1'b1, 1'b1, p);
            check_outputs();
            if (i >= 16) begin
                check_val("axes_hv", axes_hv, '0);
                check_val("axes_green", axes_green, {p, 1'b0});
                check_val("axes_blue", axes_blue, {p, 1'b0});
            end
        end
        finish_test("constant_stream");
    endtask

    task automatic ramp_gradient();
        phase_t s;
        int     d;
        for (int n = 0; n < 40; n++) begin
            s = m_st;
            tick(1'b1, 1'b1, pixel_t'(n));
            check_outputs();
            if (n >= 16) begin
                d = int'(TAP_A_IDX[s]) - int'(TAP_B_IDX[s]);
                check_val("axes_hv", axes_hv, (d < 0) ? -d : d);
            end
        end
        finish_test("ramp_gradient");
    endtask

    task automatic red_switch();
        pixel_t p;
        pixel_t q;
        int     red_shifts;
        p = pixel_t'($random(seed));
        q = p ^ 8'h5a;
        red_shifts = 0;
        for (int i = 0; i < 36; i++) begin
            tick(1'b1, 1'b1, p);
            check_outputs();
        end
        check_val("axes_red", axes_red, {p, 1'b0});
        for (int i = 0; i < 36; i++) begin
            // no red pre-value can carry q before the third edge
            if (i >= 2 && m_ctrl.red_push) begin
                red_shifts++;
            end
            tick(1'b1, 1'b1, q);
            check_outputs();
            if (red_shifts < `VNG_RED_DELAY) begin
                check_val("axes_red", axes_red, {p, 1'b0});
            end
        end
        check_val("axes_red", axes_red, {q, 1'b0});
        finish_test("red_switch");
    endtask

    task automatic enable_hold();
        for (int i = 0; i < 8; i++) begin
            tick(1'b1, 1'b1, pixel_t'($random(seed)));
            check_outputs();
        end
        // reference stands still too while disabled
        for (int i = 0; i < 6; i++) begin
            tick(1'b0, 1'b1, pixel_t'($random(seed)));
            check_outputs();
            check_val("st", i_vng_top.st, m_st);
        end
        for (int i = 0; i < 12; i++) begin
            tick(1'b1, 1'b1, pixel_t'($random(seed)));
            check_outputs();
        end
        finish_test("enable_hold");
    endtask

    initial begin
        rst_n   = 1'b0;
        clk_en  = 1'b0;
        px_push = 1'b0;
        px_in   = '0;
        m_st    = '0;
        m_ctrl  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
        idle_after_reset();
        strobe_sequence();
        constant_stream();
        ramp_gradient();
        red_switch();
        enable_hold();
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src/vng_axes.sv
module vng_axes (
    input  logic                clk,
    input  logic                clk_en,
    input  vng_pkg::pixel_t     tap_a,
    input  vng_pkg::pixel_t     tap_b,
    input  vng_pkg::axes_ctrl_t ctrl,
    input  vng_pkg::sum_t       red_diag,
    output vng_pkg::sum_t       axes_add,
    output vng_pkg::pixel_t     axes_hv,
    output logic                axes_h_push,
    output logic                axes_v_push,
    output vng_pkg::sum_t       red_pre,
    output logic                red_push,
    output logic                axes_green_push,
    output logic                axes_blue_push,
    output vng_pkg::sum_t       axes_green,
    output vng_pkg::sum_t       axes_blue
);

    import vng_pkg::*;

    sum_t dbl_a;

    // gradient, pair sum and doubled tap a
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (tap_a > tap_b) begin
                axes_hv <= tap_a - tap_b;
            end else begin
                axes_hv <= tap_b - tap_a;
            end
            axes_add <= sum_t'(tap_a) + sum_t'(tap_b);
            dbl_a    <= {tap_a, 1'b0};
        end
    end

    // strobes come straight from the registered control word
    assign axes_h_push     = ctrl.h_push;
    assign axes_v_push     = !ctrl.h_push;
    assign red_push        = ctrl.red_push;
    assign axes_green_push = ctrl.green_push;
    assign axes_blue_push  = ctrl.blue_push;

    assign axes_green = ctrl.green_sel ? axes_add : dbl_a;
    assign axes_blue  = ctrl.blue_sel ? axes_add : dbl_a;

    // red_diag port hides the enum literal, hence the scoped item
    always_comb begin
        case (ctrl.red_sel)
            red_pix:           red_pre = dbl_a;
            red_add:           red_pre = axes_add;
            vng_pkg::red_diag: red_pre = red_diag;
            default:           red_pre = dbl_a;
        endcase
    end

    // each pixel is either a horizontal or a vertical gradient sample
    a_hv_exclusive: assert property (@(posedge clk)
        !$isunknown(ctrl.h_push) |-> (axes_h_push != axes_v_push));

endmodule

//--- src/vng_ctrl_rom.sv
`include "vng_defs.svh"

module vng_ctrl_rom (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clk_en,
    input  vng_pkg::phase_t     st,
    output vng_pkg::axes_ctrl_t ctrl
);

    import vng_pkg::*;

    axes_ctrl_t ctrl_next;

    assign ctrl_next = CTRL_TABLE[st];

    // one enabled cycle behind the phase, lines up with the tap registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else if (clk_en) begin
            ctrl <= ctrl_next;
        end
    end

    a_red_sel_legal: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.red_sel inside {red_pix, red_add, red_diag});

endmodule

//--- src/vng_defs.svh
`ifndef VNG_DEFS_SVH
`define VNG_DEFS_SVH

// pixel width in bits
`define VNG_DATA 8

// phases of one 2x2 bayer cell walk
`define VNG_STATES 12

// depth of each tap shift register
`define VNG_TAPS 16

// red candidate delay, counted in red pushes
`define VNG_RED_DELAY 4

`endif

//--- src/vng_diag.sv
`include "vng_defs.svh"

module vng_diag (
    input  logic          clk,
    input  logic          clk_en,
    input  vng_pkg::sum_t axes_add,
    output vng_pkg::sum_t red_diag
);

    import vng_pkg::*;

    sum_t                 add_prev;
    logic [`VNG_DATA+1:0] pair_sum;

    // one extra bit so the pair never overflows
    assign pair_sum = {1'b0, axes_add} + {1'b0, add_prev};

    always_ff @(posedge clk) begin
        if (clk_en) begin
            add_prev <= axes_add;
            red_diag <= pair_sum[`VNG_DATA+1:1];
        end
    end

endmodule

//--- src/vng_pipedelay.sv
module vng_pipedelay #(
    parameter int WIDTH = 9,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             clk_en,
    input  logic [WIDTH-1:0] in_data,
    output logic [WIDTH-1:0] out_data
);

    logic [WIDTH-1:0] chain [DEPTH];

    // whole chain stands still while disabled
    always_ff @(posedge clk) begin
        if (clk_en) begin
            chain[0] <= in_data;
            for (int i = 1; i < DEPTH; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign out_data = chain[DEPTH-1];

endmodule

//--- src/vng_pkg.sv
`include "vng_defs.svh"

package vng_pkg;

    typedef logic [`VNG_DATA-1:0] pixel_t;
    typedef logic [`VNG_DATA:0]   sum_t;
    typedef logic [3:0]           phase_t;
    typedef logic [3:0]           tap_idx_t;

    // red pre-value source
    typedef enum logic [1:0] {
        red_pix  = 2'd0,
        red_add  = 2'd1,
        red_diag = 2'd2
    } red_sel_t;

    typedef struct packed {
        logic     h_push;
        logic     red_push;
        red_sel_t red_sel;
        logic     green_push;
        logic     green_sel;
        logic     blue_push;
        logic     blue_sel;
    } axes_ctrl_t;

    // tap positions per phase, 0 is the newest pixel
    localparam tap_idx_t TAP_A_IDX [`VNG_STATES] = '{
        4'd13, 4'd11, 4'd14, 4'd5, 4'd13, 4'd14,
        4'd13, 4'd11, 4'd15, 4'd13, 4'd13, 4'd13
    };

    localparam tap_idx_t TAP_B_IDX [`VNG_STATES] = '{
        4'd3, 4'd13, 4'd4, 4'd15, 4'd11, 4'd12,
        4'd11, 4'd1, 4'd13, 4'd3, 4'd3, 4'd11
    };

    // h_push, red_push, red_sel, green_push, green_sel, blue_push, blue_sel
    localparam axes_ctrl_t CTRL_TABLE [`VNG_STATES] = '{
        '{1'b1, 1'b0, red_diag, 1'b1, 1'b0, 1'b0, 1'b0},
        '{1'b0, 1'b1, red_pix,  1'b0, 1'b0, 1'b0, 1'b0},
        '{1'b0, 1'b1, red_add,  1'b0, 1'b0, 1'b0, 1'b0},
        '{1'b0, 1'b1, red_add,  1'b0, 1'b0, 1'b0, 1'b0},
        '{1'b1, 1'b1, red_diag, 1'b1, 1'b0, 1'b0, 1'b0},
        '{1'b0, 1'b1, red_add,  1'b1, 1'b0, 1'b0, 1'b0},
        '{1'b1, 1'b0, red_pix,  1'b0, 1'b1, 1'b1, 1'b0},
        '{1'b1, 1'b0, red_pix,  1'b1, 1'b0, 1'b1, 1'b1},
        '{1'b0, 1'b0, red_pix,  1'b0, 1'b1, 1'b1, 1'b0},
        '{1'b1, 1'b0, red_pix,  1'b0, 1'b0, 1'b1, 1'b1},
        '{1'b0, 1'b0, red_pix,  1'b1, 1'b0, 1'b1, 1'b1},
        '{1'b1, 1'b1, red_pix,  1'b1, 1'b1, 1'b0, 1'b0}
    };

endpackage

//--- src/vng_state_seq.sv
`include "vng_defs.svh"

module vng_state_seq (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clk_en,
    input  logic            px_push,
    output vng_pkg::phase_t st
);

    import vng_pkg::*;

    logic step;

    assign step = clk_en && px_push;

    // position of the current pixel within the cell walk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st <= '0;
        end else if (step) begin
            if (st == phase_t'(`VNG_STATES - 1)) begin
                st <= '0;
            end else begin
                st <= st + phase_t'(1);
            end
        end
    end

    a_st_range: assert property (@(posedge clk) disable iff (!rst_n)
        st <= phase_t'(`VNG_STATES - 1));

endmodule

//--- src/vng_tap_shiftreg.sv
`include "vng_defs.svh"

module vng_tap_shiftreg #(
    parameter vng_pkg::tap_idx_t TAP_TABLE [`VNG_STATES] = vng_pkg::TAP_A_IDX
) (
    input  logic            clk,
    input  logic            clk_en,
    input  logic            push,
    input  vng_pkg::phase_t st,
    input  vng_pkg::pixel_t px_in,
    output vng_pkg::pixel_t tap
);

    import vng_pkg::*;

    pixel_t   taps [`VNG_TAPS];
    tap_idx_t rd_idx;

    // entry 0 holds the newest pixel
    always_ff @(posedge clk) begin
        if (clk_en && push) begin
            taps[0] <= px_in;
            for (int i = 1; i < `VNG_TAPS; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign rd_idx = TAP_TABLE[st];
    assign tap    = taps[rd_idx];

endmodule

//--- src/vng_top.sv
`include "vng_defs.svh"

module vng_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clk_en,
    input  logic            px_push,
    input  vng_pkg::pixel_t px_in,
    output vng_pkg::pixel_t axes_hv,
    output logic            axes_h_push,
    output logic            axes_v_push,
    output logic            axes_red_push,
    output vng_pkg::sum_t   axes_red,
    output logic            axes_green_push,
    output vng_pkg::sum_t   axes_green,
    output logic            axes_blue_push,
    output vng_pkg::sum_t   axes_blue
);

    import vng_pkg::*;

    phase_t     st;
    pixel_t     tap_a;
    pixel_t     tap_b;
    axes_ctrl_t ctrl;
    sum_t       axes_add;
    sum_t       red_diag;
    sum_t       red_pre;
    logic       red_en;

    vng_state_seq i_state_seq (
        .clk     (clk),
        .rst_n   (rst_n),
        .clk_en  (clk_en),
        .px_push (px_push),
        .st      (st)
    );

    vng_tap_shiftreg #(
        .TAP_TABLE (TAP_A_IDX)
    ) i_tap_a (
        .clk    (clk),
        .clk_en (clk_en),
        .push   (px_push),
        .st     (st),
        .px_in  (px_in),
        .tap    (tap_a)
    );

    vng_tap_shiftreg #(
        .TAP_TABLE (TAP_B_IDX)
    ) i_tap_b (
        .clk    (clk),
        .clk_en (clk_en),
        .push   (px_push),
        .st     (st),
        .px_in  (px_in),
        .tap    (tap_b)
    );

    vng_ctrl_rom i_ctrl_rom (
        .clk    (clk),
        .rst_n  (rst_n),
        .clk_en (clk_en),
        .st     (st),
        .ctrl   (ctrl)
    );

    vng_axes i_axes (
        .clk             (clk),
        .clk_en          (clk_en),
        .tap_a           (tap_a),
        .tap_b           (tap_b),
        .ctrl            (ctrl),
        .red_diag        (red_diag),
        .axes_add        (axes_add),
        .axes_hv         (axes_hv),
        .axes_h_push     (axes_h_push),
        .axes_v_push     (axes_v_push),
        .red_pre         (red_pre),
        .red_push        (axes_red_push),
        .axes_green_push (axes_green_push),
        .axes_blue_push  (axes_blue_push),
        .axes_green      (axes_green),
        .axes_blue       (axes_blue)
    );

    vng_diag i_diag (
        .clk      (clk),
        .clk_en   (clk_en),
        .axes_add (axes_add),
        .red_diag (red_diag)
    );

    // red only advances on its own pushes
    assign red_en = clk_en && axes_red_push;

    vng_pipedelay #(
        .WIDTH ($bits(sum_t)),
        .DEPTH (`VNG_RED_DELAY)
    ) i_red_delay (
        .clk      (clk),
        .clk_en   (red_en),
        .in_data  (red_pre),
        .out_data (axes_red)
    );

endmodule
